//--- rtl/mac_pkg.sv
package mac_pkg;

    // operand width, fixed by the inverted-bit pattern of the partial product array
    localparam int OP_W = 16;

    // full signed product width
    localparam int PROD_W = 2 * OP_W;

    // one row per multiplier bit plus the constant correction row
    localparam int PP_ROWS = OP_W + 1;

    // signed two's-complement operand
    typedef logic signed [OP_W-1:0] op_t;

    // product, also used for the sum and carry vectors of the tree
    typedef logic [PROD_W-1:0] prod_t;

    // a partial product row already shifted to its weight
    typedef logic [PROD_W-1:0] pp_row_t;

    // all rows entering the carry-save tree, row 0 in the lowest slot
    typedef pp_row_t [PP_ROWS-1:0] pp_array_t;

endpackage

//--- rtl/csa_stage_if.sv
interface csa_stage_if;

    import mac_pkg::*;

    // qualifies the three fields below for one cycle
    logic valid;

    // redundant form of the product, sum plus carry modulo 2^32
    prod_t sum;
    prod_t carry;

    // high when the product adds into the accumulator, low when it loads it
    logic accumulate;

    // the reduction tree registers all four fields
    modport producer (
        output valid,
        output sum,
        output carry,
        output accumulate
    );

    // the accumulator reads each item exactly once, in the cycle valid is high
    modport consumer (
        input valid,
        input sum,
        input carry,
        input accumulate
    );

endinterface

//--- rtl/bw_partial_products.sv
module bw_partial_products (
    input  mac_pkg::op_t      a,
    input  mac_pkg::op_t      b,
    output mac_pkg::pp_array_t rows
);

    import mac_pkg::*;

    // constant that turns the inverted sign terms into an exact two's-complement sum
    // it stands for -2^31 + 2^16, which is 2^31 + 2^16 modulo 2^32
    localparam pp_row_t CORRECTION = (pp_row_t'(1) << OP_W) | (pp_row_t'(1) << (PROD_W - 1));

    // rows for multiplier bits 0 to 14 carry a negative weight only in their top bit
    for (genvar i = 0; i < OP_W - 1; i++) begin : g_row
        logic [OP_W-1:0] bits;

        assign bits[OP_W-2:0] = b[OP_W-2:0] & {(OP_W-1){a[i]}};
        assign bits[OP_W-1]   = ~(b[OP_W-1] & a[i]);

        assign rows[i] = pp_row_t'(bits) << i;
    end

    // the sign bit of a weighs negative, so the row is inverted except for b[15] & a[15],
    // which is the product of two negative weights and therefore positive
    logic [OP_W-1:0] sign_bits;

    assign sign_bits[OP_W-2:0] = ~(b[OP_W-2:0] & {(OP_W-1){a[OP_W-1]}});
    assign sign_bits[OP_W-1]   = b[OP_W-1] & a[OP_W-1];

    assign rows[OP_W-1] = pp_row_t'(sign_bits) << (OP_W - 1);

    assign rows[PP_ROWS-1] = CORRECTION;

endmodule

//--- rtl/csa_reduction_tree.sv
module csa_reduction_tree (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  logic               in_accumulate,
    input  mac_pkg::pp_array_t rows,
    csa_stage_if.producer      stage
);

    import mac_pkg::*;

    // 17 -> 12 -> 8 -> 6 -> 4 -> 3 -> 2
    localparam int LEVELS = 6;

    // every full group of three rows becomes two, leftovers pass through
    function automatic int rows_after(input int n);
        return 2 * (n / 3) + n % 3;
    endfunction

    function automatic int rows_at(input int level);
        int n;
        n = PP_ROWS;
        for (int l = 0; l < level; l++) begin
            n = rows_after(n);
        end
        return n;
    endfunction

    // lvl[0] holds the input rows, lvl[LEVELS] ends with the sum/carry pair in slots 0 and 1
    pp_array_t lvl [LEVELS+1];

    assign lvl[0] = rows;

    for (genvar l = 0; l < LEVELS; l++) begin : g_level
        localparam int N_IN  = rows_at(l);
        localparam int N_GRP = N_IN / 3;
        localparam int N_OUT = rows_after(N_IN);

        // a row of full adders per group, the carry moves one bit up in weight
        for (genvar g = 0; g < N_GRP; g++) begin : g_csa
            pp_row_t x;
            pp_row_t y;
            pp_row_t z;

            assign x = lvl[l][3*g];
            assign y = lvl[l][3*g+1];
            assign z = lvl[l][3*g+2];

            assign lvl[l+1][2*g]   = x ^ y ^ z;
            assign lvl[l+1][2*g+1] = ((x & y) | (x & z) | (y & z)) << 1;
        end

        for (genvar k = 0; k < N_IN % 3; k++) begin : g_pass
            assign lvl[l+1][2*N_GRP+k] = lvl[l][3*N_GRP+k];
        end

        // slots above the live rows of this level stay empty
        for (genvar k = N_OUT; k < PP_ROWS; k++) begin : g_idle
            assign lvl[l+1][k] = '0;
        end
    end

    // pipeline register between the tree and the final adder
    always_ff @(posedge clk) begin
        if (reset) begin
            stage.valid <= 1'b0;
        end else begin
            stage.valid <= in_valid;
        end
    end

    // the payload only changes when a new operand pair arrives
    always_ff @(posedge clk) begin
        if (in_valid) begin
            stage.sum        <= lvl[LEVELS][0];
            stage.carry      <= lvl[LEVELS][1];
            stage.accumulate <= in_accumulate;
        end
    end

endmodule

//--- rtl/mac_accumulator.sv
module mac_accumulator #(
    parameter int ACC_W = 40
) (
    input  logic             clk,
    input  logic             reset,
    csa_stage_if.consumer    stage,
    output logic             out_valid,
    output mac_pkg::prod_t   out_product,
    output logic [ACC_W-1:0] out_acc
);

    import mac_pkg::*;

    // guard bits above the product
    localparam int EXT_W = ACC_W - PROD_W;

    prod_t            product;
    logic [ACC_W-1:0] product_ext;
    logic [ACC_W-1:0] acc_next;

    // carry-propagate add, the carry out of bit 31 is dropped on purpose
    assign product = stage.sum + stage.carry;

    // the product is signed even though prod_t is a plain vector
    assign product_ext = {{EXT_W{product[PROD_W-1]}}, product};

    // accumulator wraps modulo 2^ACC_W
    always_comb begin
        if (stage.accumulate) begin
            acc_next = out_acc + product_ext;
        end else begin
            acc_next = product_ext;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_acc   <= '0;
        end else begin
            out_valid <= stage.valid;
            if (stage.valid) begin
                out_acc <= acc_next;
            end
        end
    end

    // product register holds the last result between strobes
    always_ff @(posedge clk) begin
        if (stage.valid) begin
            out_product <= product;
        end
    end

endmodule

//--- rtl/bw_mac_top.sv
module bw_mac_top #(
    parameter int ACC_W = 40
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  mac_pkg::op_t     in_a,
    input  mac_pkg::op_t     in_b,
    input  logic             in_accumulate,
    output logic             out_valid,
    output mac_pkg::prod_t   out_product,
    output logic [ACC_W-1:0] out_acc
);

    import mac_pkg::*;

    pp_array_t pp_rows;

    // registered sum/carry pair between the two pipeline stages
    csa_stage_if stage_link ();

    // combinational, same cycle as the input strobe
    bw_partial_products u_partial_products (
        .a    (in_a),
        .b    (in_b),
        .rows (pp_rows)
    );

    // first pipeline stage
    csa_reduction_tree u_reduction_tree (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_accumulate (in_accumulate),
        .rows          (pp_rows),
        .stage         (stage_link.producer)
    );

    // second pipeline stage, results appear two edges after the strobe
    mac_accumulator #(
        .ACC_W (ACC_W)
    ) u_accumulator (
        .clk         (clk),
        .reset       (reset),
        .stage       (stage_link.consumer),
        .out_valid   (out_valid),
        .out_product (out_product),
        .out_acc     (out_acc)
    );

endmodule

//--- sim/tb_bw_mac.sv
module tb_bw_mac;

    import mac_pkg::*;

    localparam int ACC_W        = 40;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int DRIVE_DELAY  = 2;

    localparam int N_RANDOM = 300;
    localparam int N_CORNER = 8;
    localparam int N_MIXED  = 200;
    localparam int N_WRAP   = 1300;
    localparam int N_BURST  = 500;
    localparam int N_RESET  = 43;
    localparam int N_TOTAL  = N_RANDOM + N_CORNER + N_MIXED + N_WRAP + N_BURST + N_RESET;

    localparam longint WATCHDOG_TIME = longint'(N_TOTAL) * CLK_PERIOD * 4
                                       + RESET_CYCLES * CLK_PERIOD;

    typedef struct packed {
        op_t  a;
        op_t  b;
        logic acc;
    } item_t;

    logic             clk;
    logic             reset;
    logic             in_valid;
    op_t              in_a;
    op_t              in_b;
    logic             in_accumulate;
    logic             out_valid;
    prod_t            out_product;
    logic [ACC_W-1:0] out_acc;

    // reference model state
    item_t            pending[$];
    logic [ACC_W-1:0] acc_model;
    logic             valid_d1;
    logic             valid_d2;
    int               error_count;
    int               strobes_accepted;
    int               results_seen;
    int               discarded;
    int               wraps;

    bw_mac_top #(
        .ACC_W (ACC_W)
    ) DUT (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_a          (in_a),
        .in_b          (in_b),
        .in_accumulate (in_accumulate),
        .out_valid     (out_valid),
        .out_product   (out_product),
        .out_acc       (out_acc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("ERROR: %s got 0x%0h expected 0x%0h at %0t", name, got, expected, $time);
        end
    endtask

    function automatic op_t random_op();
        return op_t'($urandom);
    endfunction

    task automatic send(input op_t a, input op_t b, input logic acc);
        @(posedge clk);
        #DRIVE_DELAY;
        in_valid      = 1'b1;
        in_a          = a;
        in_b          = b;
        in_accumulate = acc;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #DRIVE_DELAY;
            in_valid = 1'b0;
        end
    endtask

    // outputs are sampled half a cycle after the edge, inputs are stable there too
    always @(negedge clk) begin : monitor
        item_t            it;
        prod_t            exp_prod;
        logic [ACC_W-1:0] exp_ext;
        if (out_valid !== valid_d2) begin
            error_count++;
            if (valid_d2) begin
                $display("result missing: out_valid stayed low two cycles after a strobe at %0t",
                         $time);
            end else begin
                $display("unexpected result: out_valid high with no strobe two cycles before at %0t",
                         $time);
            end
        end
        if (out_valid === 1'b1) begin
            results_seen++;
        end
        if (valid_d2) begin
            it       = pending.pop_front();
            exp_prod = $signed(it.a) * $signed(it.b);
            exp_ext  = {{(ACC_W - 32){exp_prod[31]}}, exp_prod};
            if (it.acc) begin
                // a positive product that lands below the old value has passed 2^40
                if (!exp_prod[31] && (acc_model + exp_ext) < acc_model) begin
                    wraps++;
                end
                acc_model = acc_model + exp_ext;
            end else begin
                acc_model = exp_ext;
            end
            if (out_valid === 1'b1) begin
                check_value("out_product", out_product, exp_prod);
            end
        end
        // out_acc must hold between results as well
        check_value("out_acc", out_acc, acc_model);
        if (reset) begin
            discarded += pending.size();
            pending.delete();
            valid_d1  = 1'b0;
            valid_d2  = 1'b0;
            acc_model = '0;
        end else begin
            valid_d2 = valid_d1;
            valid_d1 = in_valid;
            if (in_valid) begin
                pending.push_back('{a: in_a, b: in_b, acc: in_accumulate});
                strobes_accepted++;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_TIME);
        $display("timeout: the run did not finish within %0d time units, errors so far %0d",
                 WATCHDOG_TIME, error_count);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : stimulus
        op_t big;
        reset            = 1'b1;
        in_valid         = 1'b0;
        in_a             = '0;
        in_b             = '0;
        in_accumulate    = 1'b0;
        acc_model        = '0;
        valid_d1         = 1'b0;
        valid_d2         = 1'b0;
        error_count      = 0;
        strobes_accepted = 0;
        results_seen     = 0;
        discarded        = 0;
        wraps            = 0;
        void'($urandom(63863));

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        // random operands with random gaps between strobes
        for (int i = 0; i < N_RANDOM; i++) begin
            send(random_op(), random_op(), 1'b0);
            idle($urandom % 4);
        end

        // corner operands
        send(-16'sd32768, -16'sd32768, 1'b0);
        send(-16'sd32768, 16'sd32767, $urandom % 2);
        send(16'sd32767, -16'sd32768, $urandom % 2);
        send(-16'sd1, -16'sd1, $urandom % 2);
        send(16'sd0, random_op(), $urandom % 2);
        send(random_op(), 16'sd0, $urandom % 2);
        send(16'sd0, -16'sd32768, $urandom % 2);
        send(16'sd32767, 16'sd32767, $urandom % 2);
        idle(3);

        // random load and add mix
        for (int i = 0; i < N_MIXED; i++) begin
            send(random_op(), random_op(), $urandom % 2);
            idle($urandom % 2);
        end

        // a long run of large positive products walks out_acc past 2^40
        for (int i = 0; i < N_WRAP; i++) begin
            big = ($urandom % 2) ? -16'sd32768 : 16'sd32767;
            if ($urandom % 8 == 0) begin
                send(random_op(), random_op(), i != 0);
            end else begin
                send(big, big, i != 0);
            end
        end
        idle(3);

        // back-to-back strobes
        for (int i = 0; i < N_BURST; i++) begin
            send(random_op(), random_op(), $urandom % 2);
        end
        idle(3);

        // reset in the middle of a burst, strobes keep coming while it is high
        for (int i = 0; i < 20; i++) begin
            send(random_op(), random_op(), 1'b1);
        end
        reset = 1'b1;
        repeat (2) send(random_op(), random_op(), 1'b1);
        send(random_op(), random_op(), 1'b1);
        reset = 1'b0;
        for (int i = 0; i < 20; i++) begin
            send(random_op(), random_op(), $urandom % 2);
        end
        idle(6);

        if (strobes_accepted != results_seen + discarded) begin
            error_count++;
            $display("result count wrong: %0d strobes accepted, %0d results, %0d discarded",
                     strobes_accepted, results_seen, discarded);
        end
        if (wraps == 0) begin
            error_count++;
            $display("the accumulator never wrapped during the run of large products");
        end
        $display("errors: %0d, results checked: %0d, discarded by reset: %0d",
                 error_count, results_seen, discarded);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
rtl/mac_pkg.sv
rtl/csa_stage_if.sv
rtl/bw_partial_products.sv
rtl/csa_reduction_tree.sv
rtl/mac_accumulator.sv
rtl/bw_mac_top.sv
sim/tb_bw_mac.sv

//--- Bender.yml
package:
  name: bw_mac

dependencies: {}

sources:
  - rtl/mac_pkg.sv
  - rtl/csa_stage_if.sv
  - rtl/bw_partial_products.sv
  - rtl/csa_reduction_tree.sv
  - rtl/mac_accumulator.sv
  - rtl/bw_mac_top.sv
  - target: simulation
    files:
      - sim/tb_bw_mac.sv
